//--- Bender.yml
package:
  name: bru

sources:
  - verilog/bru_pkg.sv
  - verilog/bru_dispatch.sv
  - verilog/bru_issue_fifo.sv
  - verilog/bru_regfile.sv
  - verilog/bru_issue.sv
  - verilog/bru_execute.sv
  - verilog/bru_result_arb.sv
  - verilog/bru_top.sv
  - target: test
    files:
      - verif/bru_tb.sv

//--- compile.f
verilog/bru_pkg.sv
verilog/bru_dispatch.sv
verilog/bru_issue_fifo.sv
verilog/bru_regfile.sv
verilog/bru_issue.sv
verilog/bru_execute.sv
verilog/bru_result_arb.sv
verilog/bru_top.sv
verif/bru_tb.sv

//--- verif/bru_tb.sv
/*
 * Self-checking testbench for the branch resolution unit.
 * Random operations from a fixed seed are predicted at dispatch and checked by tag.
 */
`timescale 1ns/1ps

module bru_tb import bru_pkg::*; ();

	localparam int N_JUMP    = 40;
	localparam int N_WAIT    = 40;
	localparam int N_BP      = 60;
	localparam int N_FLUSH   = 8;    // Thrown away by the flush.
	localparam int N_AFTER   = 20;
	localparam int TOTAL_OPS = N_JUMP + N_WAIT + N_BP + N_FLUSH + N_AFTER;

	typedef struct packed {
		int                due;   // Cycle at which the writeback may go out.
		logic [PREG_W-1:0] idx;
		logic [XLEN-1:0]   data;
	} wb_entry_t;

	logic CLK, rst_n, flush, in_valid, in_full;
	bru_issue_info_t in_info;
	logic alloc_valid, wb_valid, res_valid, res_ready;
	logic [PREG_W-1:0] alloc_idx, wb_idx;
	logic [XLEN-1:0] wb_data;
	bru_result_t res;

	// Reference model state, indexed by tag or by physical register.
	bru_result_t       exp_res [64];
	logic              outstanding [64];
	logic              jump_op [64];
	logic              need1 [64];
	logic              need2 [64];
	logic [PREG_W-1:0] src1 [64];
	logic [PREG_W-1:0] src2 [64];
	logic [NUM_PREG-1:0] mirror_log;
	logic [XLEN-1:0]   mirror_val [NUM_PREG];
	wb_entry_t         wb_q [$];

	int seed = 32'ha08e0f20;
	int cyc = 0, n_out = 0, n_sent = 0, n_res = 0, err_cnt = 0, test_err0 = 0;
	int tag_ctr = 0, reg_ptr = RP, max_delay = 0, stall_left = 0;
	logic stall_mode = 1'b0, hold_low = 1'b0, full_seen = 1'b0, held = 1'b0;
	bru_result_t held_res;

	bru_top i_bru_top (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.in_valid(in_valid), .in_info(in_info), .in_full(in_full),
		.alloc_valid(alloc_valid), .alloc_idx(alloc_idx),
		.wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
		.res_valid(res_valid), .res(res), .res_ready(res_ready)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Mostly fresh registers in rotation, now and then some rename copy of x0.
	function automatic logic [PREG_W-1:0] pick_src();
		if (rand_below(5) == 0) return PREG_W'(rand_below(RP));
		reg_ptr = (reg_ptr == NUM_PREG - 1) ? RP : reg_ptr + 1;
		return PREG_W'(reg_ptr);
	endfunction

	function automatic bru_op_e pick_op(input int kind);
		if (kind == 0) return bru_op_e'(rand_below(2));       // JAL or JALR.
		if (kind == 1) return bru_op_e'(2 + rand_below(6));   // Conditional only.
		return bru_op_e'(rand_below(8));
	endfunction

	// Branch semantics of the ISA, written out independently of the RTL.
	function automatic bru_result_t predict_result(input bru_issue_info_t op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		bru_result_t     r;
		logic [XLEN-1:0] fall;
		logic            cond;
		fall = op.pc + (op.is_rvc ? 64'd2 : 64'd4);
		case (op.op)
			OP_BEQ:  cond = (a == b);
			OP_BNE:  cond = (a != b);
			OP_BLT:  cond = ($signed(a) < $signed(b));
			OP_BGE:  cond = ($signed(a) >= $signed(b));
			OP_BLTU: cond = (a < b);
			OP_BGEU: cond = (a >= b);
			default: cond = 1'b1;   // Jumps are always taken.
		endcase
		r.tag     = op.tag;
		r.rd      = op.rd;
		r.taken   = cond;
		r.link    = fall;
		r.link_we = (op.op == OP_JAL || op.op == OP_JALR) && (op.rd >= RP);
		if (op.op == OP_JALR) r.target = (a + op.imm) & ~64'd1;
		else                  r.target = cond ? op.pc + op.imm : fall;
		return r;
	endfunction

	// Allocate a source now and schedule its writeback after a random delay.
	task automatic prepare_src(input logic [PREG_W-1:0] idx, input logic [XLEN-1:0] val);
		wb_entry_t e;
		@(posedge CLK);
		alloc_valid <= 1'b1;
		alloc_idx   <= idx;
		mirror_log[idx] = 1'b0;
		mirror_val[idx] = val;   // The value it will hold once written.
		e.due  = cyc + 2 + rand_below(max_delay + 1);
		e.idx  = idx;
		e.data = val;
		wb_q.push_back(e);
	endtask

	task automatic send_op(input bru_op_e op);
		bru_issue_info_t info;
		int              t;
		t       = tag_ctr;
		tag_ctr = (tag_ctr + 1) % 64;
		info.op     = op;
		info.is_rvc = 1'(rand_below(2));
		info.pc     = {$random(seed), $random(seed)} & ~64'd1;
		info.imm    = {$random(seed), $random(seed)};
		info.rd     = (rand_below(3) == 0) ? PREG_W'(rand_below(RP)) : pick_src();
		info.rs1    = pick_src();
		info.rs2    = pick_src();
		info.tag    = TAG_W'(t);
		need1[t] = (op != OP_JAL) && (info.rs1 >= RP);
		need2[t] = (op != OP_JAL) && (op != OP_JALR) && (info.rs2 >= RP);
		if (need1[t]) prepare_src(info.rs1, {$random(seed), $random(seed)});
		if (need2[t]) begin   // Equal operands now and then, so BEQ and BGE get taken.
			prepare_src(info.rs2, (rand_below(4) == 0) ? mirror_val[info.rs1]
				: {$random(seed), $random(seed)});
		end
		// The edge after a push shows the new in_full, so this never overfills.
		do begin
			@(posedge CLK);
			alloc_valid <= 1'b0;
			full_seen = full_seen | in_full;
		end while (in_full);
		in_valid <= 1'b1;
		in_info  <= info;
		exp_res[t] = predict_result(info, mirror_val[info.rs1], mirror_val[info.rs2]);
		jump_op[t] = (op == OP_JAL) || (op == OP_JALR);
		src1[t] = info.rs1;
		src2[t] = info.rs2;
		outstanding[t] = 1'b1;
		n_out++;
		n_sent++;
		@(posedge CLK);
		in_valid <= 1'b0;
	endtask

	task automatic compare_field(input string name, input int tag,
			input logic [XLEN-1:0] got, input logic [XLEN-1:0] expv);
		assert (got === expv) else begin
			$display("ERR res.%s tag %h got %h expected %h", name, tag, got, expv);
			err_cnt++;
		end
	endtask

	task automatic check_result(input bru_result_t r);
		bru_result_t e;
		n_res++;
		assert (outstanding[r.tag]) else begin   // Stale, duplicate or never sent.
			$display("A result came for tag %0d, which has no operation outstanding", r.tag);
			err_cnt++;
		end
		if (outstanding[r.tag]) begin
			e = exp_res[r.tag];
			outstanding[r.tag] = 1'b0;
			n_out--;
			compare_field("taken", r.tag, r.taken, e.taken);
			compare_field("target", r.tag, r.target, e.target);
			compare_field("rd", r.tag, r.rd, e.rd);
			compare_field("link_we", r.tag, r.link_we, e.link_we);
			if (jump_op[r.tag]) compare_field("link", r.tag, r.link, e.link);
			assert ((!need1[r.tag] || mirror_log[src1[r.tag]])
					&& (!need2[r.tag] || mirror_log[src2[r.tag]])) else begin
				$display("Tag %0d resolved before its sources were written back", r.tag);
				err_cnt++;
			end
		end
	endtask

	task automatic finish_test(input string name);
		int waited;
		waited = 0;
		while (n_out != 0 && waited < 600) begin
			@(posedge CLK);
			waited++;
		end
		repeat (8) @(posedge CLK);   // Gives a duplicate the chance to show up.
		assert (n_out == 0) else begin
			$display("%0d operations in test %s never produced a result", n_out, name);
			err_cnt++;
		end
		$display("Test %s: %0d errors", name, err_cnt - test_err0);
		test_err0 = err_cnt;
	endtask

	// Writeback driver, one register per cycle, and the cycle count.
	always @(posedge CLK) begin
		cyc = cyc + 1;
		wb_valid <= 1'b0;
		for (int i = 0; i < wb_q.size(); i++) begin
			if (wb_q[i].due <= cyc) begin
				wb_valid <= 1'b1;
				wb_idx   <= wb_q[i].idx;
				wb_data  <= wb_q[i].data;
				mirror_log[wb_q[i].idx] = 1'b1;
				wb_q.delete(i);
				break;
			end
		end
	end

	// Output stall pattern: long random lows and short highs in stall mode.
	always @(posedge CLK) begin
		if (hold_low || !stall_mode) begin
			res_ready  <= !hold_low;
			stall_left <= 0;
		end else if (stall_left > 0) begin
			stall_left <= stall_left - 1;
		end else if (rand_below(2) == 0) begin
			res_ready  <= 1'b0;
			stall_left <= rand_below(60);
		end else begin
			res_ready  <= 1'b1;
			stall_left <= rand_below(10);
		end
	end

	// Result monitor, with the stability rule of a stalled output.
	always @(posedge CLK) begin
		if (rst_n) begin
			if (held) begin
				assert (res_valid && res === held_res) else begin
					$display("ERR res changed while stalled, got %h expected %h", res, held_res);
					err_cnt++;
				end
			end
			held     <= res_valid && !res_ready && !flush;
			held_res <= res;
			if (res_valid && res_ready) check_result(res);
		end
	end

	initial begin
		repeat (TOTAL_OPS * 50 + 2000) @(posedge CLK);
		$display("Timeout: the run did not end within the cycle budget, %0d left", n_out);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		flush = 1'b0;
		in_valid = 1'b0;
		in_info = '0;
		alloc_valid = 1'b0;
		alloc_idx = '0;
		wb_valid = 1'b0;
		wb_idx = '0;
		wb_data = '0;
		res_ready = 1'b0;
		mirror_log = '0;   // The register file clears its log on reset.
		for (int i = 0; i < NUM_PREG; i++) mirror_val[i] = '0;
		for (int i = 0; i < 64; i++) outstanding[i] = 1'b0;
		for (int i = 0; i < 11; i++) begin
			@(posedge CLK);
			if (i == 7) rst_n <= 1'b1;   // Released after 8 cycles.
			assert (!res_valid && !in_full) else begin
				$display("res_valid or in_full went high around reset");
				err_cnt++;
			end
		end
		finish_test("reset");
		max_delay = 0;
		for (int i = 0; i < N_JUMP; i++) send_op(pick_op(0));
		finish_test("jumps");
		max_delay = 12;
		for (int i = 0; i < N_WAIT; i++) send_op(pick_op(1));
		finish_test("operand wait");
		max_delay = 3;
		stall_mode = 1'b1;
		full_seen = 1'b0;
		for (int i = 0; i < N_BP; i++) send_op(pick_op(2));
		stall_mode = 1'b0;
		assert (full_seen) else begin
			$display("in_full never rose while the output was stalled");
			err_cnt++;
		end
		finish_test("back-pressure");
		hold_low = 1'b1;   // Keeps results inside the DUT until the flush.
		for (int i = 0; i < N_FLUSH; i++) send_op(pick_op(2));
		repeat (6) @(posedge CLK);
		flush <= 1'b1;
		@(posedge CLK);
		flush <= 1'b0;
		for (int i = 0; i < 64; i++) outstanding[i] = 1'b0;
		n_out = 0;
		repeat (10) @(posedge CLK);
		hold_low = 1'b0;
		repeat (30) @(posedge CLK);   // Any old result would now arrive unknown.
		for (int i = 0; i < N_AFTER; i++) send_op(pick_op(2));
		finish_test("flush");
		$display("Done: %0d sent, %0d results, %0d errors", n_sent, n_res, err_cnt);
		if (err_cnt == 0) $display("Simulation PASSED");
		else $display("Simulation FAILED");
		$finish;
	end

endmodule

//--- verilog/bru_dispatch.sv
/*
 * Steers incoming branch operations into the lane queues, round-robin.
 * Full lanes are skipped; in_full tells the outside that no lane can take one.
 */
`timescale 1ns/1ps

module bru_dispatch import bru_pkg::*; (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  flush,
	input  logic                  in_valid,
	input  bru_issue_info_t       in_info,
	output logic                  in_full,
	input  logic [NUM_LANES-1:0]  lane_full,
	output logic [NUM_LANES-1:0]  lane_push,
	output bru_issue_info_t       lane_info
);

	logic [LANE_W-1:0] ptr;     // Preferred lane for the next operation.
	logic [LANE_W-1:0] sel;     // Lane chosen this cycle.
	logic              found;   // Some lane has room.

	assign in_full   = &lane_full;
	assign lane_info = in_info;   // Every queue sees the same entry, only one is pushed.

	// First non-full lane at or after the pointer.
	always_comb begin : pick_lane
		int idx;
		sel   = ptr;
		found = 1'b0;
		for (int i = 0; i < NUM_LANES; i++) begin
			idx = (int'(ptr) + i) % NUM_LANES;
			if (!found && !lane_full[idx]) begin
				found = 1'b1;
				sel   = LANE_W'(idx);
			end
		end
		lane_push = '0;
		if (in_valid && found && !flush) lane_push[sel] = 1'b1; // Flush drops the operation.
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (flush) begin
			ptr <= '0;
		end else if (|lane_push) begin
			ptr <= LANE_W'((int'(sel) + 1) % NUM_LANES); // Move past the lane just used.
		end
	end

	a_push_needs_valid: assert property (@(posedge CLK) disable iff (!rst_n)
		!in_valid |-> (lane_push == '0));

endmodule

//--- verilog/bru_execute.sv
/*
 * Execute stage of one lane: resolves the branch and holds the result
 * until the result arbiter grants this lane.
 */
`timescale 1ns/1ps

module bru_execute import bru_pkg::*; (
	input  logic           CLK,
	input  logic           rst_n,
	input  logic           flush,
	input  logic           exe_valid,
	input  bru_exeparam_t  exeparam,
	output logic           exe_ready,
	output logic           res_valid,
	output bru_result_t    res,
	input  logic           grant
);

	bru_result_t     res_nxt;
	logic [XLEN-1:0] next_pc;   // Fall-through address.
	logic            eq;
	logic            lt;
	logic            ltu;
	logic            is_jump;

	// Ready only with no result held and none on its way in.
	assign exe_ready = !res_valid && !exe_valid;

	assign eq      = (exeparam.op1 == exeparam.op2);
	assign lt      = ($signed(exeparam.op1) < $signed(exeparam.op2));
	assign ltu     = (exeparam.op1 < exeparam.op2);
	assign next_pc = exeparam.info.pc + (exeparam.info.is_rvc ? XLEN'(2) : XLEN'(4));
	assign is_jump = (exeparam.info.op == OP_JAL) || (exeparam.info.op == OP_JALR);

	always_comb begin
		res_nxt.tag = exeparam.info.tag;
		res_nxt.rd  = exeparam.info.rd;
		res_nxt.link = next_pc;   // Only meaningful for jumps.
		case (exeparam.info.op)
			OP_JAL, OP_JALR: res_nxt.taken = 1'b1;
			OP_BEQ:  res_nxt.taken = eq;
			OP_BNE:  res_nxt.taken = !eq;
			OP_BLT:  res_nxt.taken = lt;
			OP_BGE:  res_nxt.taken = !lt;
			OP_BLTU: res_nxt.taken = ltu;
			default: res_nxt.taken = !ltu;   // BGEU.
		endcase
		if (exeparam.info.op == OP_JALR) begin
			res_nxt.target = (exeparam.op1 + exeparam.info.imm) & ~XLEN'(1);
		end else if (res_nxt.taken) begin
			res_nxt.target = exeparam.info.pc + exeparam.info.imm;
		end else begin
			res_nxt.target = next_pc;
		end
		// A jump to x0 has no link to write.
		res_nxt.link_we = is_jump && (exeparam.info.rd[PREG_W-1:RB] != '0);
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)         res_valid <= 1'b0;
		else if (flush)     res_valid <= 1'b0;   // Drop the held result.
		else if (exe_valid) res_valid <= 1'b1;
		else if (grant)     res_valid <= 1'b0;   // Arbiter took it.
	end

	always_ff @(posedge CLK) begin
		if (exe_valid && !flush) res <= res_nxt;
	end

	// Issue must never hand over an operation while a result is still waiting here.
	a_no_overrun: assert property (@(posedge CLK) disable iff (!rst_n) exe_valid |-> !res_valid);

endmodule

//--- verilog/bru_issue.sv
/*
 * Issue stage of one lane: waits until the head operation's sources are written back,
 * then pops it and registers the operation with its operand values for execute.
 */
`timescale 1ns/1ps

module bru_issue import bru_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                fifo_empty,
	input  bru_issue_info_t     fifo_head,
	output logic                fifo_pop,
	input  logic [NUM_PREG-1:0] wb_log,
	output logic [PREG_W-1:0]   rs1_idx,
	output logic [PREG_W-1:0]   rs2_idx,
	input  logic [XLEN-1:0]     rs1_data,
	input  logic [XLEN-1:0]     rs2_data,
	input  logic                exe_ready,
	output logic                exe_valid,
	output bru_exeparam_t       exeparam
);

	logic rs1_ready;
	logic rs2_ready;
	logic ops_ready;   // The head has what its opcode needs.

	assign rs1_idx = fifo_head.rs1;   // Operands are looked up for the head only.
	assign rs2_idx = fifo_head.rs2;

	// A source is ready once logged, and x0 always is.
	assign rs1_ready = wb_log[fifo_head.rs1] | (fifo_head.rs1[PREG_W-1:RB] == '0);
	assign rs2_ready = wb_log[fifo_head.rs2] | (fifo_head.rs2[PREG_W-1:RB] == '0);

	always_comb begin
		case (fifo_head.op)
			OP_JAL:  ops_ready = 1'b1;        // No register sources.
			OP_JALR: ops_ready = rs1_ready;   // Base address only.
			default: ops_ready = rs1_ready & rs2_ready;
		endcase
	end

	assign fifo_pop = !fifo_empty && ops_ready && exe_ready && !flush;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) exe_valid <= 1'b0;
		else        exe_valid <= fifo_pop;   // One-cycle pulse per popped operation.
	end

	// Payload loads on a pop only.
	always_ff @(posedge CLK) begin
		if (fifo_pop) begin
			exeparam.info <= fifo_head;
			exeparam.op1  <= rs1_data;
			exeparam.op2  <= rs2_data;
		end
	end

endmodule

//--- verilog/bru_issue_fifo.sv
/*
 * One lane's queue of operations waiting for issue.
 * A circular buffer; the head entry is always visible to the issue stage.
 */
`timescale 1ns/1ps

module bru_issue_fifo import bru_pkg::*; (
	input  logic             CLK,
	input  logic             rst_n,
	input  logic             flush,
	input  logic             push,
	input  bru_issue_info_t  push_info,
	input  logic             pop,
	output bru_issue_info_t  head_info,
	output logic             empty,
	output logic             full
);

	bru_issue_info_t    mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW:0]   count;    // One extra bit so a full queue can be told apart.

	assign head_info = mem[rd_ptr];
	assign empty     = (count == '0);
	assign full      = (count == (FIFO_AW+1)'(FIFO_DEPTH));

	// Pointers and occupancy.
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			rd_ptr <= '0;   // Discard everything queued.
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps, the depth is a power of two.
			if (pop)  rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

	// Storage.
	always_ff @(posedge CLK) begin
		if (push && !flush) mem[wr_ptr] <= push_info;
	end

	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n) push |-> !full);
	a_no_underflow: assert property (@(posedge CLK) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- verilog/bru_pkg.sv
/*
 * Shared sizes, the branch opcode enum and the structs passed between the BRU blocks.
 * Every BRU module pulls these in with a wildcard import in its header.
 */

package bru_pkg;

	localparam int XLEN       = 64;              // Data and address width.
	localparam int RP         = 4;               // Rename copies per architectural register.
	localparam int RB         = $clog2(RP);      // Rename bits below the architectural index.
	localparam int PREG_W     = 5 + RB;          // Physical register index width.
	localparam int NUM_PREG   = 32 * RP;         // Physical registers in the file.
	localparam int NUM_LANES  = 2;               // Parallel branch lanes.
	localparam int LANE_W     = 1;               // Width of a lane index.
	localparam int FIFO_DEPTH = 4;               // Queue entries per lane.
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH); // Queue pointer width.
	localparam int TAG_W      = 6;               // Reorder-buffer tag width.

	// Branch and jump opcodes handled by the unit.
	typedef enum logic [2:0] {
		OP_JAL  = 3'd0,
		OP_JALR = 3'd1,
		OP_BEQ  = 3'd2,
		OP_BNE  = 3'd3,
		OP_BLT  = 3'd4,
		OP_BGE  = 3'd5,
		OP_BLTU = 3'd6,
		OP_BGEU = 3'd7
	} bru_op_e;

	// A decoded operation as it arrives and as it waits in a lane queue.
	typedef struct packed {
		bru_op_e             op;
		logic                is_rvc;   // Compressed encoding, so the next pc is pc + 2.
		logic [XLEN-1:0]     pc;
		logic [XLEN-1:0]     imm;
		logic [PREG_W-1:0]   rd;
		logic [PREG_W-1:0]   rs1;
		logic [PREG_W-1:0]   rs2;
		logic [TAG_W-1:0]    tag;
	} bru_issue_info_t;

	// What issue hands to execute: the operation plus its operand values.
	typedef struct packed {
		bru_issue_info_t     info;
		logic [XLEN-1:0]     op1;      // Value of rs1.
		logic [XLEN-1:0]     op2;      // Value of rs2.
	} bru_exeparam_t;

	// A resolved branch.
	typedef struct packed {
		logic [TAG_W-1:0]    tag;
		logic                taken;
		logic [XLEN-1:0]     target;   // Next pc of the resolved instruction.
		logic [PREG_W-1:0]   rd;
		logic [XLEN-1:0]     link;     // Return address for jumps.
		logic                link_we;  // Link value must be written to rd.
	} bru_result_t;

endpackage

//--- verilog/bru_regfile.sv
/*
 * Physical register values and the written-back log bits.
 * The outside allocates and writes back; each lane reads two operands combinationally.
 */
`timescale 1ns/1ps

module bru_regfile import bru_pkg::*; (
	input  logic                                    CLK,
	input  logic                                    rst_n,
	input  logic                                    alloc_valid,
	input  logic [PREG_W-1:0]                       alloc_idx,
	input  logic                                    wb_valid,
	input  logic [PREG_W-1:0]                       wb_idx,
	input  logic [XLEN-1:0]                         wb_data,
	output logic [NUM_PREG-1:0]                     wb_log,
	input  logic [NUM_LANES-1:0][1:0][PREG_W-1:0]  rd_idx,
	output logic [NUM_LANES-1:0][1:0][XLEN-1:0]    rd_data
);

	logic [XLEN-1:0] regs [NUM_PREG];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_log <= '0;
			for (int i = 0; i < NUM_PREG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// A new mapping is not yet written.
			if (alloc_valid) wb_log[alloc_idx] <= 1'b0;
			// Writeback comes last, so it wins when both name the same register.
			if (wb_valid) begin
				wb_log[wb_idx] <= 1'b1;
				regs[wb_idx]   <= wb_data;
			end
		end
	end

	// Operand reads, two per lane.
	always_comb begin
		for (int l = 0; l < NUM_LANES; l++) begin
			for (int p = 0; p < 2; p++) begin
				if (rd_idx[l][p][PREG_W-1:RB] == '0) begin
					rd_data[l][p] = '0;   // Every rename copy of x0 reads as zero.
				end else begin
					rd_data[l][p] = regs[rd_idx[l][p]];
				end
			end
		end
	end

endmodule

//--- verilog/bru_result_arb.sv
/*
 * Merges the lane results into one registered output stream.
 * Rotating priority; the output register holds until res_ready is seen high.
 */
`timescale 1ns/1ps

module bru_result_arb import bru_pkg::*; (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  logic                              flush,
	input  logic [NUM_LANES-1:0]              lane_valid,
	input  bru_result_t [NUM_LANES-1:0]       lane_res,
	output logic [NUM_LANES-1:0]              grant,
	output logic                              res_valid,
	output bru_result_t                       res,
	input  logic                              res_ready
);

	logic [LANE_W-1:0] last;    // Lane granted most recently.
	logic [LANE_W-1:0] sel;
	logic              found;
	logic              can_load;   // Output register empty or draining now.

	assign can_load = !res_valid || res_ready;

	always_comb begin : pick_lane
		int idx;
		sel   = last;
		found = 1'b0;
		for (int i = 1; i <= NUM_LANES; i++) begin   // Start one past the last grant.
			idx = (int'(last) + i) % NUM_LANES;
			if (!found && lane_valid[idx]) begin
				found = 1'b1;
				sel   = LANE_W'(idx);
			end
		end
		grant = '0;
		if (found && can_load && !flush) grant[sel] = 1'b1;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			last      <= LANE_W'(NUM_LANES - 1);   // Lane 0 goes first.
		end else if (flush) begin
			res_valid <= 1'b0;
		end else if (|grant) begin
			res_valid <= 1'b1;
			last      <= sel;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (|grant) res <= lane_res[sel];
	end

	a_grant_onehot: assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(grant));

endmodule

//--- verilog/bru_top.sv
/*
 * Branch resolution unit: dispatch, per-lane queue, issue and execute,
 * the shared register file and the result arbiter.
 */
`timescale 1ns/1ps

module bru_top import bru_pkg::*; (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                flush,
	input  logic                in_valid,
	input  bru_issue_info_t     in_info,
	output logic                in_full,
	input  logic                alloc_valid,
	input  logic [PREG_W-1:0]   alloc_idx,
	input  logic                wb_valid,
	input  logic [PREG_W-1:0]   wb_idx,
	input  logic [XLEN-1:0]     wb_data,
	output logic                res_valid,
	output bru_result_t         res,
	input  logic                res_ready
);

	logic [NUM_LANES-1:0]                   lane_full;
	logic [NUM_LANES-1:0]                   lane_push;
	bru_issue_info_t                        lane_info;    // Shared by all queues.
	bru_issue_info_t [NUM_LANES-1:0]        fifo_head;
	logic [NUM_LANES-1:0]                   fifo_empty;
	logic [NUM_LANES-1:0]                   fifo_pop;
	logic [NUM_LANES-1:0]                   exe_ready;
	logic [NUM_LANES-1:0]                   exe_valid;
	bru_exeparam_t [NUM_LANES-1:0]          exeparam;
	logic [NUM_LANES-1:0]                   lane_res_valid;
	bru_result_t [NUM_LANES-1:0]            lane_res;
	logic [NUM_LANES-1:0]                   grant;
	logic [NUM_PREG-1:0]                    wb_log;
	logic [NUM_LANES-1:0][1:0][PREG_W-1:0] rd_idx;       // Index 0 is rs1, 1 is rs2.
	logic [NUM_LANES-1:0][1:0][XLEN-1:0]   rd_data;

	bru_dispatch i_dispatch (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.in_valid(in_valid), .in_info(in_info), .in_full(in_full),
		.lane_full(lane_full), .lane_push(lane_push), .lane_info(lane_info)
	);

	bru_regfile i_regfile (
		.CLK(CLK), .rst_n(rst_n),
		.alloc_valid(alloc_valid), .alloc_idx(alloc_idx),
		.wb_valid(wb_valid), .wb_idx(wb_idx), .wb_data(wb_data),
		.wb_log(wb_log), .rd_idx(rd_idx), .rd_data(rd_data)
	);

	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		bru_issue_fifo i_fifo (
			.CLK(CLK), .rst_n(rst_n), .flush(flush),
			.push(lane_push[i]), .push_info(lane_info), .pop(fifo_pop[i]),
			.head_info(fifo_head[i]), .empty(fifo_empty[i]), .full(lane_full[i])
		);

		bru_issue i_issue (
			.CLK(CLK), .rst_n(rst_n), .flush(flush),
			.fifo_empty(fifo_empty[i]), .fifo_head(fifo_head[i]), .fifo_pop(fifo_pop[i]),
			.wb_log(wb_log), .rs1_idx(rd_idx[i][0]), .rs2_idx(rd_idx[i][1]),
			.rs1_data(rd_data[i][0]), .rs2_data(rd_data[i][1]),
			.exe_ready(exe_ready[i]), .exe_valid(exe_valid[i]), .exeparam(exeparam[i])
		);

		bru_execute i_execute (
			.CLK(CLK), .rst_n(rst_n), .flush(flush),
			.exe_valid(exe_valid[i]), .exeparam(exeparam[i]), .exe_ready(exe_ready[i]),
			.res_valid(lane_res_valid[i]), .res(lane_res[i]), .grant(grant[i])
		);
	end

	bru_result_arb i_result_arb (
		.CLK(CLK), .rst_n(rst_n), .flush(flush),
		.lane_valid(lane_res_valid), .lane_res(lane_res), .grant(grant),
		.res_valid(res_valid), .res(res), .res_ready(res_ready)
	);

endmodule
